//--- logic/cache_macros.svh
////////////////////
// cache geometry for the 68k set-associative cache controller
// 8 ways of 128 lines, eight 16-bit words per line
////////////////////

`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// set organisation
`define CACHE_WAYS   8     // ways per line
`define CACHE_LINES  128   // lines, index is address bits 10:4
`define CACHE_WORDS  8     // 16 bit words per line, word is bits 3:1

// address split
`define CACHE_TAG_W  21    // tag is address bits 31:11
`define CACHE_ADDR_W 32    // full 68k address

// lru tree width follows from the way count
// one bit per internal node of the binary tree

`endif

//--- logic/cachePkg.sv
////////////////////
// shared types for the cache controller
// state encoding and the address and way fields
////////////////////

`include "cache_macros.svh"

package cachePkg;

	// controller states
	typedef enum logic [3:0] {
		ResetState,       // one cycle after reset
		InvalidateCache,  // sweep over all lines
		Idle,
		CheckForCacheHit,
		ReadDataFromDram, // wait for dram read command
		CasDelay1,
		CasDelay2,
		BurstFill,        // eight words into the victim way
		EndBurstFill,     // dtack until end of cpu cycle
		WriteDataToDram   // write-through
	} cacheState;

	// way fields
	typedef logic [$clog2(`CACHE_WAYS)-1:0] wayIdx;   // way number
	typedef logic [`CACHE_WAYS-1:0]         wayMask;  // one bit per way
	typedef logic [`CACHE_WAYS-2:0]         lruBits;  // tree pLRU of one line

	// address fields
	typedef logic [`CACHE_TAG_W-1:0]         tagField;
	typedef logic [$clog2(`CACHE_LINES)-1:0] lineIdx;
	typedef logic [$clog2(`CACHE_WORDS)-1:0] wordIdx;
	typedef logic [`CACHE_ADDR_W-1:0]        cpuAddr;

endpackage

//--- logic/plruTree.sv
////////////////////
// tree pseudo-LRU for one cache line
// holds the line's LRU bits, encodes the hit way,
// picks and latches the victim and builds the touched bits
////////////////////

`timescale 1ns/1ps

`include "cache_macros.svh"

module plruTree (
	input  logic             Clock,
	input  logic             LruLoad,    // capture LRU bits of the addressed line
	input  cachePkg::lruBits LruIn,      // from LRU RAM
	input  cachePkg::wayMask ValidHit,   // valid and tag match, per way
	input  logic             VictimLoad, // latch the victim for the fill
	input  logic             TouchSel,   // 1 touches hit way, 0 the victim
	output logic             Hit,
	output cachePkg::wayIdx  HitWay,     // lowest hitting way
	output cachePkg::wayIdx  Victim,     // held victim during the miss
	output cachePkg::lruBits NewLru      // value to write back to LRU RAM
);

	import cachePkg::*;

	lruBits     lruHeld;   // bits of the line under access
	logic [1:0] pairSel;   // which of the four pairs the tree points at
	wayIdx      victimNow; // victim from the held bits
	wayIdx      touchWay;

	// set every node on the way's path to point away from it
	// node 0 picks the half, 1..2 the pair, 3..6 the way in a pair
	function automatic lruBits touch(input lruBits bits, input wayIdx way);
		lruBits t;
		t = bits;
		t[0] = ~way[2];                // other half
		t[1 + way[2]] = ~way[1];       // other pair in this half
		t[3 + way[2:1]] = ~way[0];     // other way of this pair
		return t;
	endfunction

	////////////////////
	// LRU register
	////////////////////

	always_ff @(posedge Clock) begin
		if (LruLoad)
			lruHeld <= LruIn;   // RAM read is addressed by the cpu index
	end

	////////////////////
	// hit encoder
	////////////////////

	// lowest numbered way wins if more than one hits
	always_comb begin
		Hit = |ValidHit;
		HitWay = '0;
		for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
			if (ValidHit[w])
				HitWay = wayIdx'(w);
		end
	end

	////////////////////
	// victim selection
	////////////////////

	// follow the bits down the tree, 0 means lower side
	always_comb begin
		pairSel[1] = lruHeld[0];                              // half
		pairSel[0] = lruHeld[0] ? lruHeld[2] : lruHeld[1];    // pair in that half
		victimNow = {pairSel, lruHeld[3 + pairSel]};          // way in the pair
	end

	// victim stays put for tag write and burst fill
	always_ff @(posedge Clock) begin
		if (VictimLoad)
			Victim <= victimNow;
	end

	////////////////////
	// tree update
	////////////////////

	// miss touches the victim chosen this cycle, not the latched one
	assign touchWay = TouchSel ? HitWay : victimNow;
	assign NewLru = touch(lruHeld, touchWay);

	// the FSM only asks for a victim when the lookup missed
	noVictimOnHit: assert property (@(posedge Clock) VictimLoad |-> !Hit)
		else $error("victim latched while a way hits");

endmodule

//--- logic/cacheFsm.sv
////////////////////
// cache controller state machine
// sweep on reset, read hit, burst fill on a miss and write-through,
// with the sweep and burst counter and the per-way strobe decode
////////////////////

`timescale 1ns/1ps

`include "cache_macros.svh"

module cacheFsm (
	input  logic              Clock,
	input  logic              Reset_L,
	// 68k side
	input  logic              DramSelect68k_H,   // dram range addressed
	input  cachePkg::cpuAddr  CpuAddr,
	input  logic              UDS_L,
	input  logic              LDS_L,
	input  logic              WE_L,              // low for a write
	input  logic              AS_L,
	output logic              DtackTo68k_L,
	// dram controller side
	input  logic              DtackFromDram_L,
	input  logic              CAS_Dram_L,        // start of CAS latency
	input  logic              RAS_Dram_L,        // high with CAS low is a read, not a refresh
	output cachePkg::cpuAddr  AddressBusOutToDramController,
	output logic              DramSelectFromCache_L,
	output logic              UDS_DramController_L,
	output logic              LDS_DramController_L,
	output logic              WE_DramController_L,
	output logic              AS_DramController_L,
	// cache RAMs
	output cachePkg::wayMask  TagCache_WE_L,
	output cachePkg::wayMask  DataCache_WE_L,
	output cachePkg::wayMask  ValidBit_WE_L,
	output cachePkg::tagField TagDataOut,
	output cachePkg::lineIdx  Index,
	output cachePkg::wordIdx  WordAddress,
	output logic              ValidBitOut_H,
	output cachePkg::lruBits  LRUBits_Out,
	output logic              LRU_WE_L,
	// pLRU tree
	input  logic              Hit,
	input  cachePkg::wayIdx   HitWay,
	input  cachePkg::wayIdx   Victim,
	input  cachePkg::lruBits  NewLru,
	output logic              LruLoad,
	output logic              VictimLoad,
	output logic              TouchSel
);

	import cachePkg::*;

	cacheState state;
	cacheState nextState;
	logic [7:0] count;      // line count in the sweep, word count in the burst
	wayMask victimWe_L;     // strobe of the victim way
	wayMask hitWe_L;        // strobe of the hitting way
	logic cpuAccess;        // 68k cycle to dram space

	// way number to a one-hot active-low strobe
	function automatic wayMask wayStrobe(input wayIdx way);
		wayStrobe = ~(wayMask'(1) << way);
	endfunction

	assign victimWe_L = wayStrobe(Victim);
	assign hitWe_L = Hit ? wayStrobe(HitWay) : '1;   // nothing to drop on a miss
	assign cpuAccess = !AS_L && DramSelect68k_H;

	////////////////////
	// state and counter
	////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L)
			state <= ResetState;
		else
			state <= nextState;
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L)
			count <= '0;
		else if (state == ResetState || state == CasDelay2)
			count <= '0;   // sweep or burst starts from zero
		else
			count <= count + 8'd1;
	end

	////////////////////
	// next state and outputs
	////////////////////

	always_comb begin
		// defaults, everything inactive
		nextState = state;
		DtackTo68k_L = 1'b1;
		AddressBusOutToDramController = {CpuAddr[`CACHE_ADDR_W-1:4], 4'b0000};  // line aligned
		DramSelectFromCache_L = 1'b1;
		UDS_DramController_L = UDS_L;
		LDS_DramController_L = LDS_L;
		WE_DramController_L = WE_L;
		AS_DramController_L = AS_L;
		TagCache_WE_L = '1;
		DataCache_WE_L = '1;
		ValidBit_WE_L = '1;
		TagDataOut = CpuAddr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];   // bits 31:11
		Index = CpuAddr[10:4];
		WordAddress = '0;
		ValidBitOut_H = 1'b0;
		LRUBits_Out = NewLru;
		LRU_WE_L = 1'b1;
		LruLoad = 1'b0;
		VictimLoad = 1'b0;
		TouchSel = 1'b0;

		case (state)
			ResetState: nextState = InvalidateCache;   // counter clears here

			InvalidateCache: begin
				// clear tag, valid and LRU of all ways for one line per cycle
				Index = lineIdx'(count);
				TagDataOut = '0;
				TagCache_WE_L = '0;
				ValidBit_WE_L = '0;
				LRUBits_Out = '0;
				LRU_WE_L = 1'b0;
				if (count == 8'(`CACHE_LINES - 1))
					nextState = Idle;
			end

			Idle: begin
				if (cpuAccess) begin
					LruLoad = 1'b1;   // RAMs are addressed by the cpu index now
					if (WE_L) begin
						UDS_DramController_L = 1'b0;   // whole word for the cache
						LDS_DramController_L = 1'b0;
						nextState = CheckForCacheHit;
					end else begin
						// write-through, drop a cached copy of the line
						ValidBit_WE_L = hitWe_L;
						AddressBusOutToDramController = CpuAddr;
						DramSelectFromCache_L = 1'b0;
						nextState = WriteDataToDram;
					end
				end
			end

			CheckForCacheHit: begin
				UDS_DramController_L = 1'b0;
				LDS_DramController_L = 1'b0;
				TouchSel = Hit;
				LRU_WE_L = 1'b0;   // hit or victim becomes most recent
				if (Hit) begin
					WordAddress = CpuAddr[3:1];
					DtackTo68k_L = 1'b0;
					if (AS_L || !DramSelect68k_H)
						nextState = Idle;
					else
						nextState = EndBurstFill;   // hold dtack to end of cycle
				end else begin
					DramSelectFromCache_L = 1'b0;   // start the dram burst
					VictimLoad = 1'b1;
					nextState = ReadDataFromDram;
				end
			end

			ReadDataFromDram: begin
				UDS_DramController_L = 1'b0;
				LDS_DramController_L = 1'b0;
				DramSelectFromCache_L = 1'b0;
				TagCache_WE_L = victimWe_L;   // new tag into the victim
				ValidBit_WE_L = victimWe_L;
				ValidBitOut_H = 1'b1;
				if (!CAS_Dram_L && RAS_Dram_L)
					nextState = CasDelay1;       // read command, refresh is ignored
			end

			CasDelay1: begin
				UDS_DramController_L = 1'b0;
				LDS_DramController_L = 1'b0;
				DramSelectFromCache_L = 1'b0;
				nextState = CasDelay2;
			end

			CasDelay2: begin
				UDS_DramController_L = 1'b0;
				LDS_DramController_L = 1'b0;
				DramSelectFromCache_L = 1'b0;
				nextState = BurstFill;   // counter restarts for the words
			end

			BurstFill: begin
				UDS_DramController_L = 1'b0;
				LDS_DramController_L = 1'b0;
				DramSelectFromCache_L = 1'b0;
				WordAddress = wordIdx'(count);   // words 0 to 7 in order
				DataCache_WE_L = victimWe_L;
				if (count == 8'(`CACHE_WORDS - 1))
					nextState = EndBurstFill;
			end

			EndBurstFill: begin
				UDS_DramController_L = 1'b0;
				LDS_DramController_L = 1'b0;
				WordAddress = CpuAddr[3:1];   // cpu word out of the cache
				DtackTo68k_L = 1'b0;
				if (AS_L || !DramSelect68k_H)
					nextState = Idle;
			end

			WriteDataToDram: begin
				AddressBusOutToDramController = CpuAddr;
				DramSelectFromCache_L = 1'b0;
				DtackTo68k_L = DtackFromDram_L;   // dram acknowledge straight to the cpu
				if (AS_L || !DramSelect68k_H)
					nextState = Idle;
			end

			default: nextState = ResetState;
		endcase
	end

	// only the victim way takes burst data
	oneDataStrobe: assert property (@(posedge Clock) disable iff (!Reset_L)
		$onehot0(~DataCache_WE_L))
		else $error("more than one data way written");

	// no cpu acknowledge before the sweep is done
	noDtackInSweep: assert property (@(posedge Clock) disable iff (!Reset_L)
		(state == InvalidateCache) |-> DtackTo68k_L)
		else $error("dtack during cache sweep");

endmodule

//--- logic/cacheController.sv
////////////////////
// 8-way set-associative cache controller for a 68000-class cpu
// state machine plus the pLRU tree, RAMs sit outside
////////////////////

`timescale 1ns/1ps

module cacheController (
	input  logic              Clock,
	input  logic              Reset_L,
	// 68k bus
	input  logic              DramSelect68k_H,
	input  cachePkg::cpuAddr  AddressBusInFrom68k,
	input  logic              UDS_L,
	input  logic              LDS_L,
	input  logic              WE_L,
	input  logic              AS_L,
	output logic              DtackTo68k_L,
	// dram controller
	input  logic              DtackFromDram_L,
	input  logic              CAS_Dram_L,
	input  logic              RAS_Dram_L,
	output cachePkg::cpuAddr  AddressBusOutToDramController,
	output logic              DramSelectFromCache_L,
	output logic              UDS_DramController_L,
	output logic              LDS_DramController_L,
	output logic              WE_DramController_L,
	output logic              AS_DramController_L,
	// tag, valid, data and LRU RAMs
	input  cachePkg::wayMask  ValidHit_H,      // per way valid and tag match
	input  cachePkg::lruBits  LRUBits_In,
	output cachePkg::wayMask  TagCache_WE_L,
	output cachePkg::wayMask  DataCache_WE_L,
	output cachePkg::wayMask  ValidBit_WE_L,
	output cachePkg::tagField TagDataOut,
	output cachePkg::lineIdx  Index,
	output cachePkg::wordIdx  WordAddress,
	output logic              ValidBitOut_H,
	output cachePkg::lruBits  LRUBits_Out,
	output logic              LRU_WE_L
);

	import cachePkg::*;

	// FSM to tree controls
	logic lruLoad;
	logic victimLoad;
	logic touchSel;
	// tree results
	logic   hit;
	wayIdx  hitWay;
	wayIdx  victim;
	lruBits newLru;

	cacheFsm fsm (
		.Clock, .Reset_L, .DramSelect68k_H, .CpuAddr(AddressBusInFrom68k),
		.UDS_L, .LDS_L, .WE_L, .AS_L, .DtackTo68k_L,
		.DtackFromDram_L, .CAS_Dram_L, .RAS_Dram_L, .AddressBusOutToDramController,
		.DramSelectFromCache_L, .UDS_DramController_L, .LDS_DramController_L,
		.WE_DramController_L, .AS_DramController_L,
		.TagCache_WE_L, .DataCache_WE_L, .ValidBit_WE_L, .TagDataOut, .Index,
		.WordAddress, .ValidBitOut_H, .LRUBits_Out, .LRU_WE_L,
		.Hit(hit), .HitWay(hitWay), .Victim(victim), .NewLru(newLru),
		.LruLoad(lruLoad), .VictimLoad(victimLoad), .TouchSel(touchSel)
	);

	plruTree lru (
		.Clock, .LruLoad(lruLoad), .LruIn(LRUBits_In), .ValidHit(ValidHit_H),
		.VictimLoad(victimLoad), .TouchSel(touchSel),
		.Hit(hit), .HitWay(hitWay), .Victim(victim), .NewLru(newLru)
	);

endmodule

//--- test/cacheMemModel.sv
////////////////////
// behavioral tag, valid and LRU RAMs plus a DRAM controller
// answers the cache controller during simulation
////////////////////

`timescale 1ns/1ps

`include "cache_macros.svh"

module cacheMemModel (
	input  logic              Clock,
	input  logic              Reset_L,
	input  cachePkg::lineIdx  Index,
	input  cachePkg::tagField TagDataOut,
	input  cachePkg::wayMask  TagCache_WE_L,
	input  cachePkg::wayMask  ValidBit_WE_L,
	input  logic              ValidBitOut_H,
	input  cachePkg::lruBits  LRUBits_Out,
	input  logic              LRU_WE_L,
	input  logic              DramSelectFromCache_L,
	input  logic              WE_DramController_L,
	input  int                AckDelay,         // cycles before the DRAM answers
	output cachePkg::wayMask  ValidHit_H,
	output cachePkg::lruBits  LRUBits_In,
	output logic              CAS_Dram_L,
	output logic              RAS_Dram_L,
	output logic              DtackFromDram_L
);

	import cachePkg::*;

	tagField tagRam [`CACHE_LINES][`CACHE_WAYS];
	logic validRam [`CACHE_LINES][`CACHE_WAYS];
	lruBits lruRam [`CACHE_LINES];
	logic selSeen = 1'b0;   // DRAM select seen low at the last rising edge
	logic weSeen = 1'b1;    // WE of the DRAM cycle, high for a read
	logic ready = 1'b0;     // DRAM has answered
	int waitCnt = 0;

	// tag compare, nothing hits while reset is low
	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++)
			ValidHit_H[w] = Reset_L && validRam[Index][w] && (tagRam[Index][w] == TagDataOut);
		LRUBits_In = Reset_L ? lruRam[Index] : '0;
	end

	////////////////////
	// RAM writes
	////////////////////

	always @(posedge Clock) begin
		if (!Reset_L) begin
			// junk that the sweep has to clear
			for (int l = 0; l < `CACHE_LINES; l++) begin
				lruRam[l] <= lruBits'(l * 3 + 1);
				for (int w = 0; w < `CACHE_WAYS; w++) begin
					tagRam[l][w] <= tagField'(l * 8 + w) ^ 21'h15a5a;
					validRam[l][w] <= ^(l * 8 + w);   // parity of line and way
				end
			end
		end else begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				if (!TagCache_WE_L[w])
					tagRam[Index][w] <= TagDataOut;
				if (!ValidBit_WE_L[w])
					validRam[Index][w] <= ValidBitOut_H;
			end
			if (!LRU_WE_L)
				lruRam[Index] <= LRUBits_Out;
		end
		if (!selSeen)
			weSeen <= WE_DramController_L;   // held for the whole DRAM cycle
		selSeen <= Reset_L && !DramSelectFromCache_L;
	end

	////////////////////
	// DRAM controller
	////////////////////

	// answers change on the falling edge only
	always @(negedge Clock) begin
		if (!selSeen) begin
			waitCnt <= 0;
			ready <= 1'b0;
		end else if (waitCnt < AckDelay)
			waitCnt <= waitCnt + 1;   // late answer stretches the FSM
		else
			ready <= 1'b1;
	end

	assign CAS_Dram_L = !(ready && weSeen);        // read command, RAS stays high
	assign RAS_Dram_L = 1'b1;
	assign DtackFromDram_L = !(ready && !weSeen);  // write acknowledge

endmodule

//--- test/cacheControllerTb.sv
////////////////////
// testbench for the cache controller
// replays accesses from a pattern file against a pLRU reference
////////////////////

`timescale 1ns/1ps

`include "cache_macros.svh"

module cacheControllerTb;

	import cachePkg::*;

	localparam int maxPatterns = 64;

	logic Clock, Reset_L, DramSelect68k_H, UDS_L, LDS_L, WE_L, AS_L, DtackTo68k_L;
	cpuAddr AddressBusInFrom68k, AddressBusOutToDramController;
	logic DtackFromDram_L, CAS_Dram_L, RAS_Dram_L, DramSelectFromCache_L;
	logic UDS_DramController_L, LDS_DramController_L, WE_DramController_L, AS_DramController_L;
	wayMask ValidHit_H, TagCache_WE_L, DataCache_WE_L, ValidBit_WE_L;
	lruBits LRUBits_In, LRUBits_Out;
	tagField TagDataOut;
	lineIdx Index;
	wordIdx WordAddress;
	logic ValidBitOut_H, LRU_WE_L;
	int AckDelay;

	logic [31:0] patterns [0:3*maxPatterns-1];   // op, address, delay per access
	tagField refTag [`CACHE_LINES][`CACHE_WAYS];
	logic refValid [`CACHE_LINES][`CACHE_WAYS];
	lruBits refLru [`CACHE_LINES];
	int errors, passed, failed, patCount, cycleLimit;
	int cycles = 0;
	string testName;

	cacheController uut (.*);
	cacheMemModel mem (.*);

	always #50 Clock = ~Clock;   // 100 ns period

	// run limit from the number of accesses
	always @(posedge Clock) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles > cycleLimit) begin
			$display("timeout after %0d cycles in %s, no acknowledge", cycles, testName);
			$display("Test failed");
			$finish;
		end
	end

	////////////////////
	// pLRU reference
	////////////////////

	// walk down from the root, 0 goes to the lower side
	function automatic wayIdx pickVictim(input lruBits b);
		int node;
		int way;
		node = 0;
		way = 0;
		for (int level = 0; level < 3; level++) begin
			way = way * 2 + int'(b[node]);
			node = 2 * node + 1 + int'(b[node]);
		end
		return wayIdx'(way);
	endfunction

	function automatic lruBits markUsed(input lruBits b, input wayIdx w);
		int node;
		node = 0;
		for (int level = 2; level >= 0; level--) begin
			b[node] = ~w[level];                  // point away
			node = 2 * node + 1 + int'(w[level]);
		end
		return b;
	endfunction

	function automatic logic lookup(input lineIdx i, input tagField t, output wayIdx w);
		lookup = 1'b0;
		w = '0;
		for (int k = `CACHE_WAYS - 1; k >= 0; k--) begin
			if (refValid[i][k] && refTag[i][k] == t) begin
				lookup = 1'b1;
				w = wayIdx'(k);   // lowest hitting way wins
			end
		end
	endfunction

	function automatic wayIdx strobeWay(input wayMask m);
		strobeWay = '0;
		for (int k = `CACHE_WAYS - 1; k >= 0; k--)
			if (!m[k])
				strobeWay = wayIdx'(k);
	endfunction

	////////////////////
	// compare tasks
	////////////////////

	task automatic checkWay(input string what, input wayIdx exp, input wayIdx act);
		if (exp !== act) begin
			errors++;
			$display("mismatch %s %s expected %0d actual %0d", testName, what, exp, act);
		end
	endtask

	task automatic checkLine(input string what, input lineIdx exp, input lineIdx act);
		if (exp !== act) begin
			errors++;
			$display("mismatch %s %s expected %0d actual %0d", testName, what, exp, act);
		end
	endtask

	task automatic checkWord(input string what, input wordIdx exp, input wordIdx act);
		if (exp !== act) begin
			errors++;
			$display("mismatch %s %s expected %0d actual %0d", testName, what, exp, act);
		end
	endtask

	task automatic checkLru(input string what, input lruBits exp, input lruBits act);
		if (exp !== act) begin
			errors++;
			$display("mismatch %s %s expected %b actual %b", testName, what, exp, act);
		end
	endtask

	task automatic checkStrobe(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			errors++;
			$display("mismatch %s %s expected %b actual %b", testName, what, exp, act);
		end
	endtask

	task automatic reportTest(input int startErr);
		if (errors == startErr) begin
			passed++;
			$display("test %s ok", testName);
		end else begin
			failed++;
			$display("test %s had %0d errors", testName, errors - startErr);
		end
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic checkSweep();
		int startErr;
		startErr = errors;
		testName = "reset sweep";
		@(posedge Clock);
		while (TagCache_WE_L !== '0)
			@(posedge Clock);
		for (int l = 0; l < `CACHE_LINES; l++) begin
			checkLine("sweep index", lineIdx'(l), Index);
			checkStrobe("all strobes low", 1'b1,
				TagCache_WE_L === '0 && ValidBit_WE_L === '0 && LRU_WE_L === 1'b0);
			checkStrobe("cleared values", 1'b1,
				TagDataOut === '0 && ValidBitOut_H === 1'b0 && LRUBits_Out === '0);
			checkStrobe("dtack in sweep", 1'b1, DtackTo68k_L);
			@(posedge Clock);
		end
		checkStrobe("tag strobes after sweep", 1'b1, TagCache_WE_L === '1);
		for (int l = 0; l < `CACHE_LINES; l++) begin
			refLru[l] = '0;
			for (int w = 0; w < `CACHE_WAYS; w++)
				refValid[l][w] = 1'b0;
		end
		reportTest(startErr);
	endtask

	task automatic runAccess(input logic isWrite, input cpuAddr a, input int delay);
		lineIdx idx;
		tagField tg;
		wayIdx hitW;
		wayIdx expWay;
		lruBits expLru;
		logic expHit;
		logic sawSelect;
		logic lruSeen;
		int words;
		int startErr;
		idx = a[10:4];
		tg = a[31:11];
		startErr = errors;
		expHit = lookup(idx, tg, hitW);
		expWay = expHit ? hitW : pickVictim(refLru[idx]);
		expLru = markUsed(refLru[idx], expWay);
		testName = $sformatf("%s %h", isWrite ? "write" : "read", a);
		sawSelect = 1'b0;
		lruSeen = 1'b0;
		words = 0;
		@(negedge Clock);
		AddressBusInFrom68k = a;
		WE_L = !isWrite;
		AckDelay = delay;
		DramSelect68k_H = 1'b1;
		UDS_L = 1'b0;
		LDS_L = 1'b0;
		AS_L = 1'b0;
		if (isWrite) begin
			@(posedge Clock);   // idle cycle drops the cached copy
			checkStrobe("valid bit out", 1'b0, ValidBitOut_H);
			if (expHit) begin
				checkStrobe("one valid strobe", 1'b1, $onehot(~ValidBit_WE_L));
				checkWay("invalidated way", hitW, strobeWay(ValidBit_WE_L));
				refValid[idx][hitW] = 1'b0;
			end else
				checkStrobe("no valid strobe", 1'b1, ValidBit_WE_L === '1);
			do begin
				@(posedge Clock);
				checkStrobe("dtack follows dram", DtackFromDram_L, DtackTo68k_L);
				checkStrobe("write address", 1'b1, AddressBusOutToDramController === a);
				checkStrobe("dram write strobe", 1'b0, WE_DramController_L);
				checkStrobe("dram address strobe", 1'b0, AS_DramController_L);
			end while (DtackTo68k_L !== 1'b0);
		end else begin
			do begin
				@(posedge Clock);
				if (DramSelectFromCache_L === 1'b0) begin
					sawSelect = 1'b1;
					checkStrobe("line address", 1'b1,
						AddressBusOutToDramController === {a[31:4], 4'h0});
					checkStrobe("dram byte strobes", 1'b0, UDS_DramController_L | LDS_DramController_L);
					checkStrobe("dram read strobe", 1'b1, WE_DramController_L);
					checkStrobe("dram address strobe", 1'b0, AS_DramController_L);
				end
				if (LRU_WE_L === 1'b0) begin
					checkStrobe("single LRU write", 1'b0, lruSeen);
					lruSeen = 1'b1;
					checkLine("LRU line", idx, Index);
					checkLru("new LRU", expLru, LRUBits_Out);
				end
				if (TagCache_WE_L !== '1) begin
					checkStrobe("one tag strobe", 1'b1, $onehot(~TagCache_WE_L));
					checkWay("tag way", expWay, strobeWay(TagCache_WE_L));
					checkStrobe("tag value", 1'b1, TagDataOut === tg && ValidBitOut_H === 1'b1);
					checkStrobe("valid with tag", 1'b1, ValidBit_WE_L === TagCache_WE_L);
				end
				if (DataCache_WE_L !== '1) begin
					checkWay("data way", expWay, strobeWay(DataCache_WE_L));
					checkWord("burst word", wordIdx'(words), WordAddress);
					words++;
				end
			end while (DtackTo68k_L !== 1'b0);
			checkWord("cpu word", a[3:1], WordAddress);
			checkStrobe("hit", expHit, !sawSelect);
			checkStrobe("LRU written", 1'b1, lruSeen);
			checkStrobe("burst length", 1'b1, words == (expHit ? 0 : 8));
			if (!expHit) begin
				refTag[idx][expWay] = tg;
				refValid[idx][expWay] = 1'b1;
			end
			refLru[idx] = expLru;
		end
		@(negedge Clock);
		AS_L = 1'b1;   // end of the cpu cycle
		DramSelect68k_H = 1'b0;
		WE_L = 1'b1;
		UDS_L = 1'b1;
		LDS_L = 1'b1;
		do
			@(posedge Clock);
		while (DtackTo68k_L !== 1'b1);
		reportTest(startErr);
	endtask

	initial begin
		Clock = 1'b0;
		Reset_L = 1'b0;
		DramSelect68k_H = 1'b0;
		AddressBusInFrom68k = '0;
		UDS_L = 1'b1;
		LDS_L = 1'b1;
		WE_L = 1'b1;
		AS_L = 1'b1;
		AckDelay = 0;
		errors = 0;
		passed = 0;
		failed = 0;
		patCount = 0;
		cycleLimit = 0;
		$readmemh("test/cachePatterns.txt", patterns);
		while (patCount < maxPatterns
			&& (patterns[3*patCount] === 32'd1 || patterns[3*patCount] === 32'd2))
			patCount++;
		cycleLimit = patCount * 40 + 200;
		repeat (10) @(posedge Clock);
		@(negedge Clock);
		Reset_L = 1'b1;
		checkSweep();
		for (int p = 0; p < patCount; p++)
			runAccess(patterns[3*p] == 32'd2, patterns[3*p+1], int'(patterns[3*p+2]));
		$display("%0d tests passed, %0d tests failed, %0d errors", passed, failed, errors);
		if (errors == 0 && patCount > 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- test/cachePatterns.txt
// columns: op (1 read, 2 write), address, DRAM acknowledge delay in cycles
// all values hex, one access per line
1 00001234 2
1 00001236 0
2 00001230 3
1 00001234 1
1 00000850 0
1 00001050 1
1 00001850 0
1 00002050 2
1 00002850 0
1 00003050 0
1 00003850 1
1 00004050 0
1 00004850 3
1 00004858 0
2 00007770 1
1 00001850 0

//--- all.f
+incdir+logic
logic/cachePkg.sv
logic/plruTree.sv
logic/cacheFsm.sv
logic/cacheController.sv
test/cacheMemModel.sv
test/cacheControllerTb.sv

//--- Makefile
# Verilator build and run of the cache controller testbench

VERILATOR ?= verilator
TOP       ?= cacheControllerTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) logic/cache_macros.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
